/* dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    localparam int word_bits = 64;
    localparam int strobe_bits = 8;
    localparam int byte_bits = 3;
    localparam int offset_bits = 2;
    localparam int index_bits = 3;
    localparam int tag_bits = 24;
    localparam int addr_bits = 32;
    localparam int len_bits = 4;
    localparam int words_per_line = 4;
    localparam int set_num = 8;

    typedef logic [word_bits-1:0] word_t;
    typedef logic [strobe_bits-1:0] strobe_t;
    typedef logic [addr_bits-1:0] addr_t;
    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [index_bits-1:0] index_t;
    typedef logic [offset_bits-1:0] offset_t;
    typedef logic [len_bits-1:0] mlen_t;

    // beats minus one for a full line burst
    localparam mlen_t line_len = mlen_t'(words_per_line - 1);

    typedef enum logic [1:0] {
        msize1,
        msize2,
        msize4,
        msize8
    } msize_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        write_back,
        refill,
        uncached,
        respond
    } state_t;

    typedef struct packed {
        logic    valid;
        addr_t   addr;
        msize_t  size;
        strobe_t strobe;
        word_t   data;
    } dbus_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t data;
    } dbus_resp_t;

    typedef struct packed {
        logic    valid;
        logic    is_write;
        msize_t  size;
        addr_t   addr;
        strobe_t strobe;
        word_t   data;
        mlen_t   len;
    } cbus_req_t;

    typedef struct packed {
        logic  ready;
        logic  last;
        word_t data;
    } cbus_resp_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } meta_t;

    function automatic tag_t get_tag(input addr_t addr);
        return addr[addr_bits-1 -: tag_bits];
    endfunction

    function automatic index_t get_index(input addr_t addr);
        return addr[byte_bits + offset_bits +: index_bits];
    endfunction

    function automatic offset_t get_offset(input addr_t addr);
        return addr[byte_bits +: offset_bits];
    endfunction

    // first byte of the line holding tag and index
    function automatic addr_t line_base(input tag_t tag, input index_t index);
        return {tag, index, {(offset_bits + byte_bits){1'b0}}};
    endfunction

endpackage

`default_nettype wire

/* dcache_way.sv */
`default_nettype none

module dcache_way (
    input  logic                clk,
    input  logic                reset,
    input  dcache_pkg::index_t  index,
    input  dcache_pkg::offset_t offset,
    input  dcache_pkg::tag_t    tag,
    input  logic                meta_we,
    input  dcache_pkg::meta_t   meta_wdata,
    input  logic                data_we,
    input  dcache_pkg::strobe_t data_strobe,
    input  dcache_pkg::word_t   wdata,
    output logic                hit,
    output dcache_pkg::meta_t   meta,
    output dcache_pkg::word_t   rdata
);

    localparam int word_num = dcache_pkg::set_num * dcache_pkg::words_per_line;

    logic [dcache_pkg::set_num-1:0] valid;
    logic [dcache_pkg::set_num-1:0] dirty;
    dcache_pkg::tag_t tags [dcache_pkg::set_num];
    dcache_pkg::word_t data [word_num];
    logic [dcache_pkg::index_bits+dcache_pkg::offset_bits-1:0] word_addr;

    // words of one line sit next to each other
    assign word_addr = {index, offset};

    always_ff @(posedge clk) begin
        if (!reset) begin
            valid <= '0;
        end else if (meta_we) begin
            valid[index] <= meta_wdata.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (meta_we) begin
            dirty[index] <= meta_wdata.dirty;
            tags[index] <= meta_wdata.tag;
        end
    end

    // byte lanes
    always_ff @(posedge clk) begin
        if (data_we) begin
            for (int i = 0; i < dcache_pkg::strobe_bits; i++) begin
                if (data_strobe[i]) begin
                    data[word_addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    assign meta.valid = valid[index];
    assign meta.dirty = dirty[index];
    assign meta.tag = tags[index];

    assign hit = valid[index] && (tags[index] == tag);
    assign rdata = data[word_addr];

endmodule

`default_nettype wire

/* dcache_ctrl.sv */
`default_nettype none

module dcache_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  dcache_pkg::dbus_req_t  dreq,
    output dcache_pkg::dbus_resp_t dresp,
    output dcache_pkg::cbus_req_t  creq,
    input  dcache_pkg::cbus_resp_t cresp,
    input  logic                   hit0,
    input  logic                   hit1,
    input  dcache_pkg::meta_t      meta0,
    input  dcache_pkg::meta_t      meta1,
    input  dcache_pkg::word_t      rdata0,
    input  dcache_pkg::word_t      rdata1,
    output dcache_pkg::index_t     index,
    output dcache_pkg::offset_t    offset,
    output dcache_pkg::tag_t       tag,
    output logic                   meta_we0,
    output logic                   meta_we1,
    output dcache_pkg::meta_t      meta_wdata,
    output logic                   data_we0,
    output logic                   data_we1,
    output dcache_pkg::strobe_t    data_strobe,
    output dcache_pkg::word_t      wdata
);

    dcache_pkg::state_t state;
    dcache_pkg::dbus_req_t req;
    dcache_pkg::word_t resp_data;
    dcache_pkg::offset_t beat;
    logic [dcache_pkg::set_num-1:0] lru;
    logic victim;
    logic hit;
    logic is_write;
    logic miss_way;
    logic miss_dirty;
    dcache_pkg::meta_t victim_meta;
    dcache_pkg::word_t victim_rdata;

    assign hit = hit0 || hit1;
    assign is_write = |req.strobe;

    assign index = dcache_pkg::get_index(req.addr);
    assign tag = dcache_pkg::get_tag(req.addr);

    // burst states walk the line, otherwise the requested word
    assign offset = (state == dcache_pkg::write_back || state == dcache_pkg::refill)
                    ? beat : dcache_pkg::get_offset(req.addr);

    // an empty way first, else the one not used last
    always_comb begin
        if (!meta0.valid) begin
            miss_way = 1'b0;
        end else if (!meta1.valid) begin
            miss_way = 1'b1;
        end else begin
            miss_way = ~lru[index];
        end
    end

    assign miss_dirty = miss_way ? (meta1.valid && meta1.dirty)
                                 : (meta0.valid && meta0.dirty);

    assign victim_meta = victim ? meta1 : meta0;
    assign victim_rdata = victim ? rdata1 : rdata0;

    assign dresp.addr_ok = (state == dcache_pkg::idle) && dreq.valid;
    assign dresp.data_ok = (state == dcache_pkg::respond);
    assign dresp.data = resp_data;

    always_comb begin
        creq = '0;
        unique case (state)
            dcache_pkg::write_back: begin
                creq.valid = 1'b1;
                creq.is_write = 1'b1;
                creq.size = dcache_pkg::msize8;
                creq.addr = dcache_pkg::line_base(victim_meta.tag, index);
                creq.strobe = '1;
                creq.data = victim_rdata;
                creq.len = dcache_pkg::line_len;
            end
            dcache_pkg::refill: begin
                creq.valid = 1'b1;
                creq.size = dcache_pkg::msize8;
                creq.addr = dcache_pkg::line_base(tag, index);
                creq.len = dcache_pkg::line_len;
            end
            dcache_pkg::uncached: begin
                creq.valid = 1'b1;
                creq.is_write = is_write;
                creq.size = req.size;
                creq.addr = req.addr;
                creq.strobe = req.strobe;
                creq.data = req.data;
                creq.len = '0;
            end
            default: begin
            end
        endcase
    end

    // way writes: store hit or refill beat
    always_comb begin
        meta_we0 = 1'b0;
        meta_we1 = 1'b0;
        data_we0 = 1'b0;
        data_we1 = 1'b0;
        meta_wdata.valid = 1'b1;
        meta_wdata.dirty = 1'b0;
        meta_wdata.tag = tag;
        data_strobe = '1;
        wdata = cresp.data;
        if (state == dcache_pkg::lookup && hit && is_write) begin
            meta_wdata.dirty = 1'b1;
            data_strobe = req.strobe;
            wdata = req.data;
            meta_we0 = hit0;
            meta_we1 = hit1;
            data_we0 = hit0;
            data_we1 = hit1;
        end else if (state == dcache_pkg::refill && cresp.ready) begin
            data_we0 = !victim;
            data_we1 = victim;
            // tag goes valid with the last word
            meta_we0 = cresp.last && !victim;
            meta_we1 = cresp.last && victim;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= dcache_pkg::idle;
            beat <= '0;
            victim <= 1'b0;
            lru <= '0;
        end else begin
            unique case (state)
                dcache_pkg::idle: begin
                    if (dreq.valid) begin
                        state <= dreq.addr[31] ? dcache_pkg::lookup : dcache_pkg::uncached;
                    end
                end
                dcache_pkg::lookup: begin
                    if (hit) begin
                        lru[index] <= hit1;
                        state <= dcache_pkg::respond;
                    end else begin
                        victim <= miss_way;
                        beat <= '0;
                        state <= miss_dirty ? dcache_pkg::write_back : dcache_pkg::refill;
                    end
                end
                dcache_pkg::write_back: begin
                    if (cresp.ready) begin
                        beat <= cresp.last ? '0 : beat + 1'b1;
                        if (cresp.last) begin
                            state <= dcache_pkg::refill;
                        end
                    end
                end
                dcache_pkg::refill: begin
                    if (cresp.ready) begin
                        beat <= cresp.last ? '0 : beat + 1'b1;
                        // look again, this time it hits
                        if (cresp.last) begin
                            state <= dcache_pkg::lookup;
                        end
                    end
                end
                dcache_pkg::uncached: begin
                    if (cresp.ready && cresp.last) begin
                        state <= dcache_pkg::respond;
                    end
                end
                dcache_pkg::respond: begin
                    state <= dcache_pkg::idle;
                end
                default: begin
                    state <= dcache_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == dcache_pkg::idle && dreq.valid) begin
            req <= dreq;
        end
        if (state == dcache_pkg::lookup && hit) begin
            resp_data <= hit1 ? rdata1 : rdata0;
        end
        if (state == dcache_pkg::uncached && cresp.ready) begin
            resp_data <= cresp.data;
        end
    end

    // a tag lives in at most one way of a set
    a_single_hit: assert property (
        @(posedge clk) disable iff (!reset)
        state == dcache_pkg::lookup |-> !(hit0 && hit1)
    );

    a_creq_stable: assert property (
        @(posedge clk) disable iff (!reset)
        creq.valid && !cresp.ready |=> $stable(creq)
    );

    // data_ok only after a hit or the last uncached beat
    a_data_ok_source: assert property (
        @(posedge clk) disable iff (!reset)
        dresp.data_ok |-> $past((state == dcache_pkg::lookup && hit)
                                || (state == dcache_pkg::uncached && cresp.ready && cresp.last))
    );

endmodule

`default_nettype wire

/* dcache_top.sv */
`default_nettype none

module dcache_top (
    input  logic                   clk,
    input  logic                   reset,
    input  dcache_pkg::dbus_req_t  dreq,
    output dcache_pkg::dbus_resp_t dresp,
    output dcache_pkg::cbus_req_t  creq,
    input  dcache_pkg::cbus_resp_t cresp
);

    dcache_pkg::index_t index;
    dcache_pkg::offset_t offset;
    dcache_pkg::tag_t tag;
    logic hit0;
    logic hit1;
    dcache_pkg::meta_t meta0;
    dcache_pkg::meta_t meta1;
    dcache_pkg::word_t rdata0;
    dcache_pkg::word_t rdata1;
    logic meta_we0;
    logic meta_we1;
    dcache_pkg::meta_t meta_wdata;
    logic data_we0;
    logic data_we1;
    dcache_pkg::strobe_t data_strobe;
    dcache_pkg::word_t wdata;

    // both ways see the same set and word
    dcache_way way0 (
        .clk(clk),
        .reset(reset),
        .index(index),
        .offset(offset),
        .tag(tag),
        .meta_we(meta_we0),
        .meta_wdata(meta_wdata),
        .data_we(data_we0),
        .data_strobe(data_strobe),
        .wdata(wdata),
        .hit(hit0),
        .meta(meta0),
        .rdata(rdata0)
    );

    dcache_way way1 (
        .clk(clk),
        .reset(reset),
        .index(index),
        .offset(offset),
        .tag(tag),
        .meta_we(meta_we1),
        .meta_wdata(meta_wdata),
        .data_we(data_we1),
        .data_strobe(data_strobe),
        .wdata(wdata),
        .hit(hit1),
        .meta(meta1),
        .rdata(rdata1)
    );

    dcache_ctrl ctrl (.*);

endmodule

`default_nettype wire

/* tb_mem_model.sv */
`default_nettype none

module tb_mem_model #(
    parameter dcache_pkg::word_t fill_key = 64'h0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  dcache_pkg::cbus_req_t  creq,
    output dcache_pkg::cbus_resp_t cresp
);

    timeunit 1ns;
    timeprecision 1ps;

    // sparse word store, keyed by aligned byte address
    dcache_pkg::word_t store [dcache_pkg::addr_t];
    dcache_pkg::mlen_t beat;
    logic [31:0] rnd;

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic dcache_pkg::word_t read_word(input dcache_pkg::addr_t a);
        if (store.exists(a)) begin
            return store[a];
        end
        return {~a, a} ^ fill_key;
    endfunction

    function automatic dcache_pkg::addr_t beat_addr(input dcache_pkg::addr_t base,
                                                    input dcache_pkg::mlen_t n);
        return {base[31:3], 3'b000} + 32'({n, 3'b000});
    endfunction

    initial begin
        cresp = '0;
        beat = '0;
        rnd = 32'h8569b508;
    end

    always @(posedge clk) begin
        dcache_pkg::addr_t a;
        dcache_pkg::word_t w;
        if (!reset) begin
            beat = '0;
        end else if (creq.valid && cresp.ready) begin
            a = beat_addr(creq.addr, beat);
            if (creq.is_write) begin
                w = read_word(a);
                for (int i = 0; i < dcache_pkg::strobe_bits; i++) begin
                    if (creq.strobe[i]) begin
                        w[8*i +: 8] = creq.data[8*i +: 8];
                    end
                end
                store[a] = w;
            end
            beat = cresp.last ? '0 : beat + 1'b1;
        end
        #1;
        // roughly one beat in four stalls
        rnd = lcg_next(rnd);
        cresp.ready = creq.valid && (rnd[17:16] != 2'b00);
        cresp.last = cresp.ready && (beat == creq.len);
        if (creq.valid && !creq.is_write) begin
            cresp.data = read_word(beat_addr(creq.addr, beat));
        end else begin
            cresp.data = '0;
        end
    end

endmodule

`default_nettype wire

/* tb_dcache.sv */
`default_nettype none

module tb_dcache;

    timeunit 1ns;
    timeprecision 1ps;

    localparam dcache_pkg::word_t fill_key = 64'h3c96_a5f0_0f5a_c369;
    localparam int request_num = 21;
    localparam int cycle_bound = 200;

    logic clk;
    logic reset;
    dcache_pkg::dbus_req_t dreq;
    dcache_pkg::dbus_resp_t dresp;
    dcache_pkg::cbus_req_t creq;
    dcache_pkg::cbus_resp_t cresp;

    dcache_pkg::word_t shadow [dcache_pkg::addr_t];
    dcache_pkg::word_t expect_data;
    dcache_pkg::word_t wb_expect;
    logic hit_check;
    logic quiet;
    logic [1:0] wb_beat;
    int wb_beats;
    int issued = 0;
    int errors = 0;

    dcache_top dut (
        .clk(clk),
        .reset(reset),
        .dreq(dreq),
        .dresp(dresp),
        .creq(creq),
        .cresp(cresp)
    );

    tb_mem_model #(.fill_key(fill_key)) mem (
        .clk(clk),
        .reset(reset),
        .creq(creq),
        .cresp(cresp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic dcache_pkg::addr_t word_addr(input dcache_pkg::addr_t a);
        return {a[31:3], 3'b000};
    endfunction

    function automatic dcache_pkg::word_t shadow_read(input dcache_pkg::addr_t a);
        if (shadow.exists(word_addr(a))) begin
            return shadow[word_addr(a)];
        end
        return {~word_addr(a), word_addr(a)} ^ fill_key;
    endfunction

    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old,
                                                      input dcache_pkg::word_t data,
                                                      input dcache_pkg::strobe_t strobe);
        dcache_pkg::word_t w;
        w = old;
        for (int i = 0; i < dcache_pkg::strobe_bits; i++) begin
            if (strobe[i]) begin
                w[8*i +: 8] = data[8*i +: 8];
            end
        end
        return w;
    endfunction

    // holds the request until data_ok, as the processor would
    task automatic access(input dcache_pkg::addr_t addr, input dcache_pkg::msize_t size,
                          input dcache_pkg::strobe_t strobe, input dcache_pkg::word_t data,
                          input logic expect_hit);
        dreq.valid = 1'b1;
        dreq.addr = addr;
        dreq.size = size;
        dreq.strobe = strobe;
        dreq.data = data;
        expect_data = shadow_read(addr);
        hit_check = expect_hit;
        issued++;
        do @(negedge clk); while (!dresp.data_ok);
        if (strobe != 8'h00) begin
            shadow[word_addr(addr)] = merge_bytes(shadow_read(addr), data, strobe);
        end
        @(posedge clk);
        #1;
        dreq = '0;
        hit_check = 1'b0;
    endtask

    // write-back beat counter and the expected word of the next beat
    always @(posedge clk) begin
        if (!reset) begin
            wb_beat <= 2'd0;
            wb_beats <= 0;
        end else if (creq.valid && creq.is_write && creq.addr[31] && cresp.ready) begin
            wb_beat <= wb_beat + 1'b1;
            wb_beats <= wb_beats + 1;
        end
    end

    always @(posedge clk) begin
        #2;
        wb_expect = shadow_read(creq.addr + 32'({wb_beat, 3'b000}));
    end

    a_quiet: assert property (@(posedge clk)
        quiet |-> !dresp.addr_ok && !dresp.data_ok && !creq.valid)
        else begin
            errors++;
            $display("cache outputs active during or just after reset");
        end

    a_read_data: assert property (@(posedge clk) disable iff (!reset)
        dresp.data_ok && dreq.strobe == 8'h00 |-> dresp.data == expect_data)
        else begin
            errors++;
            $display("mismatch dresp.data at %h got %h expected %h", $sampled(dreq.addr),
                     $sampled(dresp.data), $sampled(expect_data));
        end

    a_hit_latency: assert property (@(posedge clk) disable iff (!reset)
        dresp.data_ok && hit_check |-> $past(dresp.addr_ok, 2))
        else begin
            errors++;
            $display("hit at %h not answered two cycles after addr_ok", $sampled(dreq.addr));
        end

    a_wb_data: assert property (@(posedge clk) disable iff (!reset)
        creq.valid && creq.is_write && creq.addr[31] && cresp.ready |-> creq.data == wb_expect)
        else begin
            errors++;
            $display("mismatch creq.data got %h expected %h", $sampled(creq.data),
                     $sampled(wb_expect));
        end

    a_line_len: assert property (@(posedge clk) disable iff (!reset)
        creq.valid && creq.addr[31] |-> creq.len == 4'd3)
        else begin
            errors++;
            $display("mismatch creq.len got %h expected 3", $sampled(creq.len));
        end

    a_unc_addr: assert property (@(posedge clk) disable iff (!reset)
        creq.valid && !creq.addr[31] |-> creq.addr == dreq.addr)
        else begin
            errors++;
            $display("mismatch creq.addr got %h expected %h", $sampled(creq.addr),
                     $sampled(dreq.addr));
        end

    a_unc_shape: assert property (@(posedge clk) disable iff (!reset)
        creq.valid && !creq.addr[31]
        |-> creq.len == 4'd0 && creq.size == dreq.size && creq.strobe == dreq.strobe
            && creq.is_write == (dreq.strobe != 8'h00)
            && (dreq.strobe == 8'h00 || creq.data == dreq.data))
        else begin
            errors++;
            $display("mismatch creq len/size/strobe/is_write got %h/%h/%h/%h expected 0/%h/%h/%h",
                     $sampled(creq.len), $sampled(creq.size), $sampled(creq.strobe),
                     $sampled(creq.is_write), $sampled(dreq.size), $sampled(dreq.strobe),
                     $sampled(dreq.strobe != 8'h00));
            $display("mismatch creq.data got %h expected %h", $sampled(creq.data),
                     $sampled(dreq.data));
        end

    // uncached traffic is a single beat
    a_unc_single: assert property (@(posedge clk) disable iff (!reset)
        creq.valid && !creq.addr[31] && cresp.ready |=> !creq.valid)
        else begin
            errors++;
            $display("uncached transfer kept the memory bus after its only beat");
        end

    initial begin
        repeat (16 + request_num * cycle_bound) @(posedge clk);
        $display("timeout after %0d of %0d requests, %0d errors", issued, request_num, errors);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        dreq = '0;
        expect_data = '0;
        hit_check = 1'b0;
        reset = 1'b0;
        quiet = 1'b0;
        @(posedge clk);
        #1;
        quiet = 1'b1;
        repeat (15) @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        quiet = 1'b0;

        // cold miss, then hits on the same line
        for (int i = 0; i < 4; i++) begin
            access(32'h8000_1000 + 8 * i, dcache_pkg::msize8, 8'h00, 64'h0, i != 0);
        end

        // partial strobes merge into cached words
        access(32'h8000_1008, dcache_pkg::msize8, 8'h0f, 64'h1111_2222_3333_4444, 1'b1);
        access(32'h8000_1008, dcache_pkg::msize8, 8'h3c, 64'haaaa_bbbb_cccc_dddd, 1'b1);
        access(32'h8000_1010, dcache_pkg::msize4, 8'hf0, 64'h5555_6666_7777_8888, 1'b1);
        access(32'h8000_1008, dcache_pkg::msize8, 8'h00, 64'h0, 1'b1);
        access(32'h8000_1010, dcache_pkg::msize8, 8'h00, 64'h0, 1'b1);

        // three lines of set 0 force dirty evictions
        access(32'h8000_1118, dcache_pkg::msize8, 8'hff, 64'hdead_beef_0123_4567, 1'b0);
        access(32'h8000_1200, dcache_pkg::msize8, 8'h00, 64'h0, 1'b0);
        access(32'h8000_1008, dcache_pkg::msize8, 8'h00, 64'h0, 1'b0);

        // rotate three lines through set 2
        for (int i = 0; i < 6; i++) begin
            access(32'h8000_3040 + 32'h100 * (i % 3) + 8 * (i % 4), dcache_pkg::msize8,
                   (i % 2 == 0) ? 8'hc3 : 8'h00, 64'h0123_4567_89ab_cdef ^ 64'(i), 1'b0);
        end

        access(32'h0000_2008, dcache_pkg::msize4, 8'h0f, 64'hffff_ffff_cafe_f00d, 1'b0);
        access(32'h0000_2008, dcache_pkg::msize8, 8'h00, 64'h0, 1'b0);
        access(32'h0000_2010, dcache_pkg::msize2, 8'h00, 64'h0, 1'b0);

        a_wb_seen: assert (wb_beats > 0)
            else begin
                errors++;
                $display("no write-back burst was seen on the memory bus");
            end

        repeat (4) @(posedge clk);
        $display("requests %0d, write-back beats %0d, errors %0d", issued, wb_beats, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
dcache_pkg.sv
dcache_way.sv
dcache_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_dcache
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= sim.f
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell cat $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
